//--- src/periph_pkg.sv
// Shared APB bus types, register offsets and serial state encodings for the peripheral subsystem
package periph_pkg;

	// -------------------------------------------------------------------
	// APB bus

	localparam int W_PADDR = 16;
	localparam int W_DATA  = 32;

	// Everything the master drives
	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [W_PADDR-1:0] paddr;
		logic [W_DATA-1:0]  pwdata;
	} apb_req_t;

	// Everything a slave returns
	typedef struct packed {
		logic [W_DATA-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// -------------------------------------------------------------------
	// Register offsets

	// Machine timer, CTRL bit 0 is the counter enable
	typedef enum logic [7:0] {
		CTRL      = 8'h00,
		MTIME     = 8'h08,
		MTIMEH    = 8'h0C,
		MTIMECMP  = 8'h10,
		MTIMECMPH = 8'h14
	} timer_reg_e;

	// UART, CSR holds status in bits 1:0 and interrupt enables in bits 9:8
	typedef enum logic [7:0] {
		CSR    = 8'h00,
		DIV    = 8'h04,
		TXDATA = 8'h08,
		RXDATA = 8'h0C
	} uart_reg_e;

	// -------------------------------------------------------------------
	// Serial shifter states

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- src/apb_splitter.sv
// APB address splitter routing one master to the timer, the UART or an error response
`timescale 1ns/1ps

module apb_splitter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t src_req,
	output periph_pkg::apb_rsp_t src_rsp,
	output periph_pkg::apb_req_t timer_req,
	input  periph_pkg::apb_rsp_t timer_rsp,
	output periph_pkg::apb_req_t uart_req,
	input  periph_pkg::apb_rsp_t uart_rsp
);
	import periph_pkg::*;

	typedef enum logic [1:0] {SEL_TIMER, SEL_UART, SEL_NONE} sel_e;

	sel_e sel_addr;
	sel_e sel_q;
	sel_e sel;
	logic setup;
	logic access;

	assign setup  = src_req.psel && !src_req.penable;
	assign access = src_req.psel && src_req.penable;

	// Top two address bits pick the slave
	always_comb begin
		case (src_req.paddr[W_PADDR-1 -: 2])
			2'b00:   sel_addr = SEL_TIMER;
			2'b01:   sel_addr = SEL_UART;
			default: sel_addr = SEL_NONE;
		endcase
	end

	// Decode captured in the setup cycle and held through the access cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= SEL_NONE;
		end else if (setup) begin
			sel_q <= sel_addr;
		end
	end

	assign sel = access ? sel_q : sel_addr;

	always_comb begin
		timer_req      = src_req;
		timer_req.psel = src_req.psel && (sel == SEL_TIMER);
		uart_req       = src_req;
		uart_req.psel  = src_req.psel && (sel == SEL_UART);
	end

	// Unmapped space completes at once with an error
	always_comb begin
		case (sel)
			SEL_TIMER: src_rsp = timer_rsp;
			SEL_UART:  src_rsp = uart_rsp;
			default: begin
				src_rsp.prdata  = '0;
				src_rsp.pready  = access;
				src_rsp.pslverr = access;
			end
		endcase
	end

endmodule

//--- src/riscv_timer.sv
// RISC-V machine timer with 64-bit mtime and mtimecmp, debug freeze and compare interrupt
`timescale 1ns/1ps

module riscv_timer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,
	input  logic                 dbg_halt,
	output logic                 timer_irq
);
	import periph_pkg::*;

	timer_reg_e  reg_sel;
	logic        access;
	logic        wr_en;
	logic        en;
	logic [63:0] mtime;
	logic [63:0] mtimecmp;

	assign reg_sel = timer_reg_e'(apb_req.paddr[7:0]);
	assign access  = apb_req.psel && apb_req.penable;
	assign wr_en   = access && apb_req.pwrite;

	// -------------------------------------------------------------------
	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en <= 1'b0;
		end else if (wr_en && reg_sel == CTRL) begin
			en <= apb_req.pwdata[0];
		end
	end

	// Bus writes to either half take priority over counting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && reg_sel == MTIME) begin
			mtime[31:0] <= apb_req.pwdata;
		end else if (wr_en && reg_sel == MTIMEH) begin
			mtime[63:32] <= apb_req.pwdata;
		end else if (en && !dbg_halt) begin
			mtime <= mtime + 64'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (wr_en && reg_sel == MTIMECMP) begin
			mtimecmp[31:0] <= apb_req.pwdata;
		end else if (wr_en && reg_sel == MTIMECMPH) begin
			mtimecmp[63:32] <= apb_req.pwdata;
		end
	end

	// Compare registered one cycle behind the counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// -------------------------------------------------------------------
	// Read path

	always_comb begin
		case (reg_sel)
			CTRL:      apb_rsp.prdata = W_DATA'(en);
			MTIME:     apb_rsp.prdata = mtime[31:0];
			MTIMEH:    apb_rsp.prdata = mtime[63:32];
			MTIMECMP:  apb_rsp.prdata = mtimecmp[31:0];
			MTIMECMPH: apb_rsp.prdata = mtimecmp[63:32];
			default:   apb_rsp.prdata = '0;
		endcase
		apb_rsp.pready  = access;
		apb_rsp.pslverr = 1'b0;
	end

endmodule

//--- src/uart_tx_shifter.sv
// UART transmit shifter sending start, eight data bits LSB first and stop
`timescale 1ns/1ps

module uart_tx_shifter (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [7:0]  data,
	input  logic [15:0] div,
	output logic        busy,
	output logic        tx
);
	import periph_pkg::*;

	tx_state_e   state;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shreg;
	logic        bit_end;

	// Last clock of the current bit period
	assign bit_end = (cnt == div - 16'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
		end else if (state == TX_IDLE) begin
			cnt     <= '0;
			bit_idx <= '0;
			if (start) begin
				state <= TX_START;
			end
		end else if (bit_end) begin
			cnt <= '0;
			case (state)
				TX_START: state <= TX_DATA;
				TX_DATA: begin
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7) begin
						state <= TX_STOP;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end else begin
			cnt <= cnt + 16'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && start) begin
			shreg <= data;
		end else if (state == TX_DATA && bit_end) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

	// Line idles high
	always_comb begin
		case (state)
			TX_START: tx = 1'b0;
			TX_DATA:  tx = shreg[0];
			default:  tx = 1'b1;
		endcase
	end

	assign busy = (state != TX_IDLE);

endmodule

//--- src/uart_rx_shifter.sv
// UART receive shifter detecting a start bit and sampling each bit at its middle
`timescale 1ns/1ps

module uart_rx_shifter (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rx,
	input  logic [15:0] div,
	output logic        byte_valid,
	output logic [7:0]  data
);
	import periph_pkg::*;

	logic        rx_meta;
	logic        rx_sync;
	rx_state_e   state;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shreg;
	logic        half_end;
	logic        bit_end;

	assign half_end = (cnt == (div >> 1) - 16'd1);
	assign bit_end  = (cnt == div - 16'd1);

	// Two-flop synchroniser, idle level high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= RX_IDLE;
			cnt        <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				// Glitches shorter than half a bit fall back to idle
				RX_START: begin
					if (half_end) begin
						cnt   <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
				default: begin
					if (bit_end) begin
						cnt        <= '0;
						state      <= RX_IDLE;
						byte_valid <= rx_sync;
					end else begin
						cnt <= cnt + 16'd1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end) begin
			shreg <= {rx_sync, shreg[7:1]};
		end
	end

	assign data = shreg;

endmodule

//--- src/uart_mini.sv
// Minimal UART with divider, single holding registers and an interrupt
`timescale 1ns/1ps

module uart_mini #(
	parameter logic [15:0] DIV_RESET = 16'd16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,
	input  logic                 rx,
	output logic                 tx,
	output logic                 irq
);
	import periph_pkg::*;

	uart_reg_e   reg_sel;
	logic        access;
	logic        wr_en;
	logic        rd_en;
	logic [15:0] div;
	logic        tx_ie;
	logic        rx_ie;
	logic        tx_start;
	logic        tx_busy;
	logic        rx_byte_valid;
	logic [7:0]  rx_byte;
	logic [7:0]  rx_hold;
	logic        rx_valid;

	assign reg_sel = uart_reg_e'(apb_req.paddr[7:0]);
	assign access  = apb_req.psel && apb_req.penable;
	assign wr_en   = access && apb_req.pwrite;
	assign rd_en   = access && !apb_req.pwrite;

	// -------------------------------------------------------------------
	// Control registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div   <= DIV_RESET;
			tx_ie <= 1'b0;
			rx_ie <= 1'b0;
		end else begin
			if (wr_en && reg_sel == CSR) begin
				tx_ie <= apb_req.pwdata[8];
				rx_ie <= apb_req.pwdata[9];
			end
			if (wr_en && reg_sel == DIV) begin
				div <= apb_req.pwdata[15:0];
			end
		end
	end

	// Writes while a frame is going out are dropped
	assign tx_start = wr_en && (reg_sel == TXDATA) && !tx_busy;

	// -------------------------------------------------------------------
	// Receive holding register

	always_ff @(posedge clk) begin
		if (rx_byte_valid) begin
			rx_hold <= rx_byte;
		end
	end

	// A new byte wins over a same-cycle read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
		end else if (rx_byte_valid) begin
			rx_valid <= 1'b1;
		end else if (rd_en && reg_sel == RXDATA) begin
			rx_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq <= 1'b0;
		end else begin
			irq <= (rx_valid && rx_ie) || (!tx_busy && tx_ie);
		end
	end

	always_comb begin
		case (reg_sel)
			CSR:     apb_rsp.prdata = W_DATA'({rx_ie, tx_ie, 6'd0, rx_valid, tx_busy});
			DIV:     apb_rsp.prdata = W_DATA'(div);
			RXDATA:  apb_rsp.prdata = W_DATA'(rx_hold);
			default: apb_rsp.prdata = '0;
		endcase
		apb_rsp.pready  = access;
		apb_rsp.pslverr = 1'b0;
	end

	uart_tx_shifter tx_u (
		.clk   (clk),
		.rst_n (rst_n),
		.start (tx_start),
		.data  (apb_req.pwdata[7:0]),
		.div   (div),
		.busy  (tx_busy),
		.tx    (tx)
	);

	uart_rx_shifter rx_u (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx         (rx),
		.div        (div),
		.byte_valid (rx_byte_valid),
		.data       (rx_byte)
	);

endmodule

//--- src/periph_soc.sv
// Peripheral subsystem connecting one APB master to the machine timer and the UART
`timescale 1ns/1ps

module periph_soc #(
	parameter logic [15:0] DIV_RESET = 16'd16
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,
	input  logic                 dbg_halt,
	input  logic                 uart_rx,
	output logic                 uart_tx,
	output logic                 uart_irq,
	output logic                 timer_irq
);
	import periph_pkg::*;

	// -------------------------------------------------------------------
	// Bus fabric
	//   timer at ... 0x0000
	//   UART at .... 0x4000
	//   0x8000 and up is unmapped

	apb_req_t timer_req;
	apb_rsp_t timer_rsp;
	apb_req_t uart_req;
	apb_rsp_t uart_rsp;

	apb_splitter splitter_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.src_req   (apb_req),
		.src_rsp   (apb_rsp),
		.timer_req (timer_req),
		.timer_rsp (timer_rsp),
		.uart_req  (uart_req),
		.uart_rsp  (uart_rsp)
	);

	// -------------------------------------------------------------------
	// Peripherals

	riscv_timer timer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req   (timer_req),
		.apb_rsp   (timer_rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	uart_mini #(
		.DIV_RESET (DIV_RESET)
	) uart_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (uart_req),
		.apb_rsp (uart_rsp),
		.rx      (uart_rx),
		.tx      (uart_tx),
		.irq     (uart_irq)
	);

endmodule

//--- verification/tb_apb_tasks.svh
// APB master tasks and the check and test counting helpers for the peripheral testbench
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
	check_cnt++;
	assert (got === exp) else begin
		$display("ERR %s: got 0x%08h exp 0x%08h", name, got, exp);
		err_cnt++;
	end
endtask

task automatic expect_true(input logic cond, input string what);
	check_cnt++;
	assert (cond === 1'b1) else begin
		$display("%s", what);
		err_cnt++;
	end
endtask

task automatic begin_test(input string name);
	test_num++;
	test_name = name;
	err_at_start = err_cnt;
endtask

task automatic end_test();
	if (err_cnt == err_at_start) begin
		$display("test %0d %s: ok", test_num, test_name);
	end else begin
		$display("test %0d %s: %0d errors", test_num, test_name, err_cnt - err_at_start);
	end
endtask

// -------------------------------------------------------------------
// APB master

// Access phase, sampled at the rising edge where pready is seen
task automatic complete_access(output logic [31:0] data);
	int waits;
	waits = 0;
	@(posedge clk);
	while (!apb_rsp.pready && waits < 16) begin
		waits++;
		@(posedge clk);
	end
	expect_true(apb_rsp.pready, $sformatf("APB access to 0x%04h never saw pready", apb_req.paddr));
	data       = apb_rsp.prdata;
	last_err   = apb_rsp.pslverr;
	last_cycle = cycle;
	@(negedge clk);
	apb_req.psel    = 1'b0;
	apb_req.penable = 1'b0;
endtask

task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
	logic [31:0] unused;
	@(negedge clk);
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = 1'b1;
	apb_req.paddr   = addr;
	apb_req.pwdata  = data;
	@(negedge clk);
	apb_req.penable = 1'b1;
	complete_access(unused);
endtask

task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
	@(negedge clk);
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = 1'b0;
	apb_req.paddr   = addr;
	@(negedge clk);
	apb_req.penable = 1'b1;
	complete_access(data);
endtask

`endif

//--- verification/tb_periph_soc.sv
// Testbench for the peripheral subsystem with the UART looped back on itself
`timescale 1ns/1ps

module tb_periph_soc;
	import periph_pkg::*;

	localparam logic [15:0] TIMER_BASE = 16'h0000;
	localparam logic [15:0] UART_BASE  = 16'h4000;
	// Five frames of 160 cycles, timer waits and register traffic stay far below this
	localparam int unsigned CYCLE_LIMIT = 20000;
	localparam int POLL_LIMIT = 100;
	localparam int IRQ_WAIT   = 400;

	logic        clk;
	logic        rst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        dbg_halt;
	logic        uart_tx;
	logic        uart_irq;
	logic        timer_irq;

	int unsigned cycle = 0;
	int unsigned last_cycle;
	logic        last_err;
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          test_num = 0;
	int          err_at_start;
	string       test_name;

	periph_soc #(
		.DIV_RESET (16'd16)
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.dbg_halt  (dbg_halt),
		.uart_rx   (uart_tx),
		.uart_tx   (uart_tx),
		.uart_irq  (uart_irq),
		.timer_irq (timer_irq)
	);

	`include "tb_apb_tasks.svh"

	task automatic poll_csr(input logic [31:0] mask, input logic [31:0] value, input string what);
		logic [31:0] csr;
		int polls;
		polls = 0;
		apb_read(UART_BASE + 16'(CSR), csr);
		while ((csr & mask) != value && polls < POLL_LIMIT) begin
			polls++;
			apb_read(UART_BASE + 16'(CSR), csr);
		end
		expect_true((csr & mask) == value, what);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// -------------------------------------------------------------------
	// Bus and line properties

	ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
	else begin
		$display("ERR pready: got 0x1 with psel 0x%0h penable 0x%0h",
			apb_req.psel, apb_req.penable);
		err_cnt++;
	end

	// A CSR read that reports the transmitter idle must see the line high
	tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		(apb_req.psel && apb_req.penable && !apb_req.pwrite
			&& apb_req.paddr == UART_BASE + 16'(CSR)
			&& apb_rsp.pready && !apb_rsp.prdata[0]) |-> uart_tx)
	else begin
		$display("ERR uart_tx: got 0x%0h exp 0x1 while CSR reads not busy", uart_tx);
		err_cnt++;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Run stopped at the cycle limit, tx shifter %s, rx shifter %s",
				i_dut.uart_u.tx_u.state.name(), i_dut.uart_u.rx_u.state.name());
			$display("Simulation FAILED");
			$finish;
		end
	end

	// -------------------------------------------------------------------
	// Stimulus

	initial begin
		logic [31:0] rd;
		logic [31:0] t0;
		logic [31:0] t1;
		logic [31:0] v;
		logic [7:0]  b;
		int unsigned c0;
		int          waits;

		void'($urandom(32'h871f_d75a));
		rst_n    = 1'b0;
		apb_req  = '0;
		dbg_halt = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		begin_test("reset values");
		expect_eq("uart_tx", uart_tx, 32'h1);
		expect_eq("uart_irq", uart_irq, 32'h0);
		expect_eq("timer_irq", timer_irq, 32'h0);
		apb_read(UART_BASE + 16'(DIV), rd);
		expect_eq("DIV", rd, 32'd16);
		apb_read(UART_BASE + 16'(CSR), rd);
		expect_eq("CSR", rd, 32'h0);
		apb_read(TIMER_BASE + 16'(CTRL), rd);
		expect_eq("CTRL", rd, 32'h0);
		apb_read(TIMER_BASE + 16'(MTIMECMP), rd);
		expect_eq("MTIMECMP", rd, 32'hffff_ffff);
		apb_read(TIMER_BASE + 16'(MTIMECMPH), rd);
		expect_eq("MTIMECMPH", rd, 32'hffff_ffff);
		end_test();

		begin_test("timer count and freeze");
		apb_write(TIMER_BASE + 16'(CTRL), 32'h1);
		apb_read(TIMER_BASE + 16'(MTIME), t0);
		c0 = last_cycle;
		repeat (20) @(negedge clk);
		apb_read(TIMER_BASE + 16'(MTIME), t1);
		expect_true(t1 - t0 >= (last_cycle - c0) - 2,
			$sformatf("mtime moved only %0d counts over %0d cycles", t1 - t0, last_cycle - c0));
		dbg_halt = 1'b1;
		apb_read(TIMER_BASE + 16'(MTIME), t0);
		repeat (12) @(negedge clk);
		apb_read(TIMER_BASE + 16'(MTIME), t1);
		expect_eq("MTIME halted", t1, t0);
		dbg_halt = 1'b0;
		apb_write(TIMER_BASE + 16'(CTRL), 32'h0);
		v = $urandom;
		apb_write(TIMER_BASE + 16'(MTIME), v);
		apb_read(TIMER_BASE + 16'(MTIME), rd);
		expect_eq("MTIME", rd, v);
		end_test();

		begin_test("timer interrupt");
		apb_write(TIMER_BASE + 16'(MTIMECMP), 32'd50);
		apb_write(TIMER_BASE + 16'(MTIME), 32'h0);
		apb_write(TIMER_BASE + 16'(MTIMEH), 32'h0);
		apb_write(TIMER_BASE + 16'(MTIMECMPH), 32'h0);
		expect_eq("timer_irq", timer_irq, 32'h0);
		apb_write(TIMER_BASE + 16'(CTRL), 32'h1);
		// Each falling edge sees the interrupt for the count reached at the edge before
		for (int k = 1; k <= 52; k++) begin
			@(negedge clk);
			if (k < 50) begin
				expect_eq("timer_irq", timer_irq, 32'h0);
			end
		end
		expect_eq("timer_irq", timer_irq, 32'h1);
		apb_write(TIMER_BASE + 16'(MTIMECMPH), 32'hffff_ffff);
		repeat (2) @(negedge clk);
		expect_eq("timer_irq", timer_irq, 32'h0);
		apb_write(TIMER_BASE + 16'(CTRL), 32'h0);
		end_test();

		begin_test("uart loopback");
		apb_write(UART_BASE + 16'(DIV), 32'd16);
		for (int n = 0; n < 4; n++) begin
			b = 8'($urandom);
			poll_csr(32'h1, 32'h0, "UART transmitter stayed busy");
			apb_write(UART_BASE + 16'(TXDATA), {24'h0, b});
			poll_csr(32'h2, 32'h2, $sformatf("Byte 0x%02h never arrived at the receiver", b));
			apb_read(UART_BASE + 16'(RXDATA), rd);
			expect_eq("RXDATA", rd, {24'h0, b});
			apb_read(UART_BASE + 16'(CSR), rd);
			expect_eq("CSR.rx_valid", rd[1], 32'h0);
		end
		end_test();

		begin_test("uart interrupt");
		poll_csr(32'h1, 32'h0, "UART transmitter stayed busy");
		apb_write(UART_BASE + 16'(CSR), 32'h200);
		expect_eq("uart_irq", uart_irq, 32'h0);
		b = 8'($urandom);
		apb_write(UART_BASE + 16'(TXDATA), {24'h0, b});
		waits = 0;
		while (!uart_irq && waits < IRQ_WAIT) begin
			@(negedge clk);
			waits++;
		end
		expect_true(uart_irq, "uart_irq did not rise after a byte was received");
		apb_read(UART_BASE + 16'(RXDATA), rd);
		expect_eq("RXDATA", rd, {24'h0, b});
		repeat (2) @(negedge clk);
		expect_eq("uart_irq", uart_irq, 32'h0);
		poll_csr(32'h1, 32'h0, "UART transmitter stayed busy");
		apb_write(UART_BASE + 16'(CSR), 32'h100);
		repeat (2) @(negedge clk);
		expect_eq("uart_irq", uart_irq, 32'h1);
		apb_write(UART_BASE + 16'(CSR), 32'h0);
		repeat (2) @(negedge clk);
		expect_eq("uart_irq", uart_irq, 32'h0);
		end_test();

		begin_test("address decode");
		apb_read(16'h8000, rd);
		expect_eq("pslverr", last_err, 32'h1);
		expect_eq("prdata", rd, 32'h0);
		apb_write(16'h8000, 32'hdead_beef);
		expect_eq("pslverr", last_err, 32'h1);
		apb_read(UART_BASE + 16'h0040, rd);
		expect_eq("pslverr", last_err, 32'h0);
		expect_eq("prdata", rd, 32'h0);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+verification
src/periph_pkg.sv
src/apb_splitter.sv
src/riscv_timer.sv
src/uart_tx_shifter.sv
src/uart_rx_shifter.sv
src/uart_mini.sv
src/periph_soc.sv
verification/tb_periph_soc.sv
